// ==== design/fp_csr_defs.svh ====
/*
  CSR addresses, funct3 codes and rounding-mode codes for the FP status path.
  Included by the modules that decode CSR accesses or rounding modes.
*/
`ifndef FP_CSR_DEFS_SVH
`define FP_CSR_DEFS_SVH

// floating-point CSR addresses
`define FP_CSR_FFLAGS_ADDR 12'h001
`define FP_CSR_FRM_ADDR    12'h002
`define FP_CSR_FCSR_ADDR   12'h003

// bit 2 of funct3 selects the immediate source
`define FP_CSRRW_F3  3'b001
`define FP_CSRRS_F3  3'b010
`define FP_CSRRC_F3  3'b011
`define FP_CSRRWI_F3 3'b101
`define FP_CSRRSI_F3 3'b110
`define FP_CSRRCI_F3 3'b111

// rm field value that defers to frm
`define FP_RM_DYN 3'd7

// acceptance to result latency of every unit
`define FP_PIPE_DEPTH 2

`endif

// ==== design/fp_csr_pkg.sv ====
/*
  Types on the CSR side of the FP status path.
  Flag order follows the ISA, NV in bit 4 down to NX in bit 0.
*/
`default_nettype none

package fp_csr_pkg;

  // accrued exception flags {nv, dz, of, uf, nx}
  typedef logic [4:0] fflags_t;

  // codes 5 and 6 are reserved and 7 is dynamic
  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } frm_e;

  // frm in [7:5] and fflags in [4:0]
  typedef logic [7:0] fcsr_t;

  typedef logic [11:0] csr_addr_t;

endpackage

`default_nettype wire

// ==== design/fp_op_pkg.sv ====
/*
  Types on the operation side of the FP status path.
  Single precision only, so every data word is 32 bits.
*/
`default_nettype none

package fp_op_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;

  typedef enum logic [2:0] {
    OP_CSR, OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX, OP_CVT_W, OP_CVT_WU
  } fp_op_e;

endpackage

`default_nettype wire

// ==== design/fcsr_unit.sv ====
/*
  fflags/frm/fcsr state with CSR read-modify-write and flag accrual.
  A CSR access must not coincide with accrual; the issue logic enforces it.
  Unknown addresses read as zero with csr_hit_o low and write nothing.
*/
`timescale 1ns/100ps
`default_nettype none
`include "fp_csr_defs.svh"

module fcsr_unit
  import fp_csr_pkg::*;
  import fp_op_pkg::*;
(
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               csr_v_i,
  input  logic [2:0]         csr_funct3_i,
  input  reg_idx_t           csr_imm_i,
  input  fcsr_t              csr_wdata_i,
  input  csr_addr_t          csr_addr_i,
  input  logic [1:0]         flags_v_i,
  input  fflags_t [1:0]      flags_i,
  output fcsr_t              csr_rdata_o,
  output logic               csr_hit_o,
  output frm_e               frm_o
);

  logic [2:0] frm_q;
  fflags_t    fflags_q;
  fcsr_t      wmask;
  fcsr_t      wdata;
  fcsr_t      imm_ext;
  logic [2:0] frm_mask;
  logic [2:0] frm_data;
  fflags_t    fflags_mask;
  fflags_t    fflags_data;
  fflags_t    accrued;
  logic       hits_fflags;

  assign imm_ext = {3'b000, csr_imm_i};

  // mask and data over the full fcsr image
  always_comb begin
    wmask = '0;
    wdata = '0;
    if (csr_v_i) begin
      case (csr_funct3_i)
        `FP_CSRRW_F3: begin
          wmask = '1;
          wdata = csr_wdata_i;
        end
        `FP_CSRRS_F3: begin
          wmask = csr_wdata_i;
          wdata = csr_wdata_i;
        end
        `FP_CSRRC_F3: begin
          wmask = csr_wdata_i;
          wdata = ~csr_wdata_i;
        end
        `FP_CSRRWI_F3: begin
          wmask = '1;
          wdata = imm_ext;
        end
        `FP_CSRRSI_F3: begin
          wmask = imm_ext;
          wdata = imm_ext;
        end
        `FP_CSRRCI_F3: begin
          wmask = imm_ext;
          wdata = ~imm_ext;
        end
        default: ;
      endcase
    end
  end

  assign hits_fflags = (csr_addr_i == `FP_CSR_FFLAGS_ADDR) ||
                       (csr_addr_i == `FP_CSR_FCSR_ADDR);

  // frm sits at the bottom of its own CSR but above fflags in fcsr
  always_comb begin
    frm_mask = '0;
    frm_data = '0;
    if (csr_addr_i == `FP_CSR_FRM_ADDR) begin
      frm_mask = wmask[2:0];
      frm_data = wdata[2:0];
    end else if (csr_addr_i == `FP_CSR_FCSR_ADDR) begin
      frm_mask = wmask[7:5];
      frm_data = wdata[7:5];
    end
  end

  assign fflags_mask = hits_fflags ? wmask[4:0] : '0;
  assign fflags_data = hits_fflags ? wdata[4:0] : '0;
  assign accrued = ({5{flags_v_i[0]}} & flags_i[0]) | ({5{flags_v_i[1]}} & flags_i[1]);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frm_q    <= '0;
      fflags_q <= '0;
    end else begin
      frm_q <= (frm_q & ~frm_mask) | (frm_data & frm_mask);
      if (csr_v_i) begin
        fflags_q <= (fflags_q & ~fflags_mask) | (fflags_data & fflags_mask);
      end else begin
        fflags_q <= fflags_q | accrued;
      end
    end
  end

  // read port returns the old value of the addressed field
  always_comb begin
    csr_hit_o   = 1'b1;
    csr_rdata_o = '0;
    case (csr_addr_i)
      `FP_CSR_FFLAGS_ADDR: csr_rdata_o = {3'b000, fflags_q};
      `FP_CSR_FRM_ADDR:    csr_rdata_o = {5'b00000, frm_q};
      `FP_CSR_FCSR_ADDR:   csr_rdata_o = {frm_q, fflags_q};
      default:             csr_hit_o = 1'b0;
    endcase
  end

  assign frm_o = frm_e'(frm_q);

  // issue logic holds CSR accesses until both units have drained
  assert property (@(posedge clk_i) disable iff (reset_i)
    (csr_v_i && hits_fflags) |-> (flags_v_i == 2'b00))
    else $error("flag accrual overlaps a CSR access to fflags");

endmodule

`default_nettype wire

// ==== design/fp_compare.sv ====
/*
  Two-stage single-precision feq, flt, fle, fmin and fmax.
  Subnormals compare as-is; only NV is ever raised.
*/
`timescale 1ns/100ps
`default_nettype none

module fp_compare
  import fp_csr_pkg::*;
  import fp_op_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  logic    v_i,
  input  fp_op_e  op_i,
  input  word_t   a_i,
  input  word_t   b_i,
  output logic    v_o,
  output word_t   result_o,
  output fflags_t flags_o
);

  localparam word_t canon_nan = 32'h7fc0_0000;

  logic   s1_v_q;
  fp_op_e s1_op_q;
  word_t  a_q;
  word_t  b_q;
  logic   a_nan, b_nan, a_snan, b_snan;
  logic   any_nan, any_snan, both_zero;
  logic   equal, less, a_below_b;
  word_t  result_d;
  logic   nv;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_q <= 1'b0;
      v_o    <= 1'b0;
    end else begin
      s1_v_q <= v_i;
      v_o    <= s1_v_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      s1_op_q <= op_i;
      a_q     <= a_i;
      b_q     <= b_i;
    end
    if (s1_v_q) begin
      result_o <= result_d;
      flags_o  <= {nv, 4'b0000};
    end
  end

  // the quiet bit is the mantissa msb
  assign a_nan     = (a_q[30:23] == 8'hff) && (a_q[22:0] != '0);
  assign b_nan     = (b_q[30:23] == 8'hff) && (b_q[22:0] != '0);
  assign a_snan    = a_nan && !a_q[22];
  assign b_snan    = b_nan && !b_q[22];
  assign any_nan   = a_nan || b_nan;
  assign any_snan  = a_snan || b_snan;
  assign both_zero = (a_q[30:0] == '0) && (b_q[30:0] == '0);

  // sign-magnitude order where -0 ranks below +0 for min/max
  always_comb begin
    if (a_q[31] != b_q[31]) begin
      a_below_b = a_q[31];
    end else if (a_q[31]) begin
      a_below_b = a_q[30:0] > b_q[30:0];
    end else begin
      a_below_b = a_q[30:0] < b_q[30:0];
    end
  end

  assign equal = !any_nan && ((a_q == b_q) || both_zero);
  assign less  = !any_nan && a_below_b && !both_zero;

  always_comb begin
    result_d = '0;
    nv       = 1'b0;
    case (s1_op_q)
      OP_FEQ: begin
        result_d = {31'd0, equal};
        nv       = any_snan;
      end
      OP_FLT: begin
        result_d = {31'd0, less};
        nv       = any_nan;
      end
      OP_FLE: begin
        result_d = {31'd0, less || equal};
        nv       = any_nan;
      end
      OP_FMIN, OP_FMAX: begin
        nv = any_snan;
        if (a_nan && b_nan) begin
          result_d = canon_nan;
        end else if (a_nan) begin
          result_d = b_q;
        end else if (b_nan) begin
          result_d = a_q;
        end else if (a_below_b == (s1_op_q == OP_FMIN)) begin
          result_d = a_q;
        end else begin
          result_d = b_q;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/fp_cvt_int.sv ====
/*
  Two-stage fcvt.w.s / fcvt.wu.s with static or dynamic rounding.
  Out-of-range and NaN inputs saturate with NV, NaN counts as positive.
  A frm holding a reserved code rounds as RNE.
*/
`timescale 1ns/100ps
`default_nettype none
`include "fp_csr_defs.svh"

module fp_cvt_int
  import fp_csr_pkg::*;
  import fp_op_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       v_i,
  input  fp_op_e     op_i,
  input  logic [2:0] rm_i,
  input  frm_e       frm_i,
  input  word_t      a_i,
  output logic       v_o,
  output word_t      result_o,
  output fflags_t    flags_o
);

  logic [7:0]  exp;
  logic [23:0] sig;
  logic [63:0] aligned;
  logic        tiny;
  frm_e        rm_s1;

  logic        s1_v_q;
  fp_op_e      s1_op_q;
  frm_e        rm_q;
  logic        sign_q, nan_q, big_q;
  logic [31:0] int_q;
  logic        guard_q, sticky_q;

  logic        round_up, neg, in_range;
  logic [32:0] mag;
  word_t       conv, sat;

  // stage one puts the integer bits in [63:32] with guard at bit 31
  assign exp  = a_i[30:23];
  assign sig  = {exp != 8'd0, a_i[22:0]};
  assign tiny = exp < 8'd126;

  always_comb begin
    aligned = {8'd0, sig, 32'd0};
    if (exp >= 8'd150) begin
      aligned = aligned << (exp - 8'd150);
    end else begin
      aligned = aligned >> (8'd150 - exp);
    end
  end

  assign rm_s1 = (rm_i == `FP_RM_DYN) ? frm_i : frm_e'(rm_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      s1_v_q <= 1'b0;
      v_o    <= 1'b0;
    end else begin
      s1_v_q <= v_i;
      v_o    <= s1_v_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i) begin
      s1_op_q  <= op_i;
      rm_q     <= rm_s1;
      sign_q   <= a_i[31];
      nan_q    <= (exp == 8'hff) && (a_i[22:0] != '0);
      // 2^32 and beyond, infinities included
      big_q    <= exp >= 8'd159;
      int_q    <= tiny ? '0 : aligned[63:32];
      guard_q  <= tiny ? 1'b0 : aligned[31];
      sticky_q <= tiny ? (a_i[30:0] != '0) : (aligned[30:0] != '0);
    end
    if (s1_v_q) begin
      result_o <= in_range ? conv : sat;
      flags_o  <= {!in_range, 3'b000, in_range && (guard_q || sticky_q)};
    end
  end

  // stage two rounds and then checks the range
  always_comb begin
    case (rm_q)
      RTZ:     round_up = 1'b0;
      RDN:     round_up = sign_q && (guard_q || sticky_q);
      RUP:     round_up = !sign_q && (guard_q || sticky_q);
      RMM:     round_up = guard_q;
      default: round_up = guard_q && (sticky_q || int_q[0]);
    endcase
  end

  assign mag = {1'b0, int_q} + {32'd0, round_up};
  assign neg = sign_q && !nan_q;

  always_comb begin
    if (s1_op_q == OP_CVT_WU) begin
      in_range = !nan_q && !big_q && (neg ? (mag == '0) : !mag[32]);
      conv     = mag[31:0];
      sat      = neg ? 32'h0000_0000 : 32'hffff_ffff;
    end else begin
      in_range = !nan_q && !big_q &&
                 (neg ? (mag <= 33'h0_8000_0000) : (mag <= 33'h0_7fff_ffff));
      conv     = neg ? (~mag[31:0] + 32'd1) : mag[31:0];
      sat      = neg ? 32'h8000_0000 : 32'h7fff_ffff;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    v_i |-> !(rm_i inside {3'd5, 3'd6}))
    else $error("reserved rounding mode on conversion");

endmodule

`default_nettype wire

// ==== design/fp_issue_ctrl.sv ====
/*
  In-flight count, CSR stall and result merge for the FP status path.
  Operations never return in the same cycle since both units share one latency.
*/
`timescale 1ns/100ps
`default_nettype none
`include "fp_csr_defs.svh"

module fp_issue_ctrl
  import fp_csr_pkg::*;
  import fp_op_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     in_v_i,
  input  fp_op_e   in_op_i,
  input  fcsr_t    csr_rdata_i,
  input  logic     csr_hit_i,
  input  reg_idx_t in_rd_i,
  input  logic     cmp_v_i,
  input  word_t    cmp_result_i,
  input  logic     cvt_v_i,
  input  word_t    cvt_result_i,
  output logic     in_ready_o,
  output logic     cmp_v_o,
  output logic     cvt_v_o,
  output logic     csr_v_o,
  output logic     res_v_o,
  output word_t    res_data_o,
  output reg_idx_t res_rd_o,
  output logic     res_illegal_o
);

  localparam int last = `FP_PIPE_DEPTH - 1;

  logic [1:0]                inflight_q;
  logic                      accept, is_csr, is_cvt;
  logic [`FP_PIPE_DEPTH-1:0] csr_v_q;
  logic [`FP_PIPE_DEPTH-1:0] illegal_q;
  fcsr_t                     csr_data_q [`FP_PIPE_DEPTH];
  reg_idx_t                  rd_q [`FP_PIPE_DEPTH];

  assign is_csr = in_op_i == OP_CSR;
  assign is_cvt = (in_op_i == OP_CVT_W) || (in_op_i == OP_CVT_WU);

  // a CSR access waits until every operation has accrued its flags
  assign in_ready_o = !(in_v_i && is_csr && (inflight_q != 2'd0));
  assign accept     = in_v_i && in_ready_o;
  assign csr_v_o    = accept && is_csr;
  assign cvt_v_o    = accept && is_cvt;
  assign cmp_v_o    = accept && !is_csr && !is_cvt;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      inflight_q <= '0;
      csr_v_q    <= '0;
    end else begin
      inflight_q <= inflight_q + {1'b0, cmp_v_o || cvt_v_o} - {1'b0, cmp_v_i || cvt_v_i};
      csr_v_q    <= {csr_v_q[last-1:0], csr_v_o};
    end
  end

  // tags and CSR read data ride alongside the unit pipelines
  always_ff @(posedge clk_i) begin
    csr_data_q[0] <= csr_rdata_i;
    illegal_q[0]  <= !csr_hit_i;
    rd_q[0]       <= in_rd_i;
    for (int i = 1; i < `FP_PIPE_DEPTH; i++) begin
      csr_data_q[i] <= csr_data_q[i-1];
      illegal_q[i]  <= illegal_q[i-1];
      rd_q[i]       <= rd_q[i-1];
    end
  end

  assign res_v_o       = cmp_v_i || cvt_v_i || csr_v_q[last];
  assign res_rd_o      = rd_q[last];
  assign res_illegal_o = csr_v_q[last] && illegal_q[last];

  always_comb begin
    if (cmp_v_i) begin
      res_data_o = cmp_result_i;
    end else if (cvt_v_i) begin
      res_data_o = cvt_result_i;
    end else if (csr_v_q[last]) begin
      res_data_o = {24'd0, csr_data_q[last]};
    end else begin
      res_data_o = '0;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) !(cmp_v_i && cvt_v_i))
    else $error("compare and convert results collide");

endmodule

`default_nettype wire

// ==== design/fp_csr_top.sv ====
/*
  FP status path top: issue control, compare, convert and fcsr state.
  Input is valid/ready, result is valid-only two cycles after acceptance.
*/
`timescale 1ns/100ps
`default_nettype none

module fp_csr_top
  import fp_csr_pkg::*;
  import fp_op_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       in_v_i,
  input  fp_op_e     in_op_i,
  input  logic [2:0] in_funct3_i,
  input  reg_idx_t   in_rs1_i,
  input  csr_addr_t  in_csr_addr_i,
  input  word_t      in_a_i,
  input  word_t      in_b_i,
  input  reg_idx_t   in_rd_i,
  output logic       in_ready_o,
  output logic       res_v_o,
  output word_t      res_data_o,
  output reg_idx_t   res_rd_o,
  output logic       res_illegal_o
);

  logic    cmp_v, cvt_v, csr_v;
  logic    cmp_res_v, cvt_res_v;
  word_t   cmp_result, cvt_result;
  fflags_t cmp_flags, cvt_flags;
  fcsr_t   csr_rdata;
  logic    csr_hit;
  frm_e    frm;

  fp_issue_ctrl issue0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .in_v_i        (in_v_i),
    .in_op_i       (in_op_i),
    .csr_rdata_i   (csr_rdata),
    .csr_hit_i     (csr_hit),
    .in_rd_i       (in_rd_i),
    .cmp_v_i       (cmp_res_v),
    .cmp_result_i  (cmp_result),
    .cvt_v_i       (cvt_res_v),
    .cvt_result_i  (cvt_result),
    .in_ready_o    (in_ready_o),
    .cmp_v_o       (cmp_v),
    .cvt_v_o       (cvt_v),
    .csr_v_o       (csr_v),
    .res_v_o       (res_v_o),
    .res_data_o    (res_data_o),
    .res_rd_o      (res_rd_o),
    .res_illegal_o (res_illegal_o)
  );

  fp_compare cmp0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (cmp_v),
    .op_i     (in_op_i),
    .a_i      (in_a_i),
    .b_i      (in_b_i),
    .v_o      (cmp_res_v),
    .result_o (cmp_result),
    .flags_o  (cmp_flags)
  );

  // funct3 doubles as the rm field on conversions
  fp_cvt_int cvt0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .v_i      (cvt_v),
    .op_i     (in_op_i),
    .rm_i     (in_funct3_i),
    .frm_i    (frm),
    .a_i      (in_a_i),
    .v_o      (cvt_res_v),
    .result_o (cvt_result),
    .flags_o  (cvt_flags)
  );

  fcsr_unit fcsr0 (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .csr_v_i      (csr_v),
    .csr_funct3_i (in_funct3_i),
    .csr_imm_i    (in_rs1_i),
    .csr_wdata_i  (in_a_i[7:0]),
    .csr_addr_i   (in_csr_addr_i),
    .flags_v_i    ({cvt_res_v, cmp_res_v}),
    .flags_i      ({cvt_flags, cmp_flags}),
    .csr_rdata_o  (csr_rdata),
    .csr_hit_o    (csr_hit),
    .frm_o        (frm)
  );

endmodule

`default_nettype wire

// ==== verification/fp_csr_tb.sv ====
/*
  Random instruction stream for the FP status path, seeded with 79.
  A reference model of fflags, frm and both units predicts every result.
  Reserved frm codes are modelled as round-to-nearest-even.
*/
`timescale 1ns/100ps
`default_nettype none
`include "fp_csr_defs.svh"

module fp_csr_tb
  import fp_csr_pkg::*;
  import fp_op_pkg::*;
();

  localparam int num_instr     = 1500;
  localparam int timeout_limit = 10 * num_instr + 100;

  logic       clk_i = 1'b0;
  logic       reset_i;
  logic       in_v_i;
  fp_op_e     in_op_i;
  logic [2:0] in_funct3_i;
  reg_idx_t   in_rs1_i;
  csr_addr_t  in_csr_addr_i;
  word_t      in_a_i;
  word_t      in_b_i;
  reg_idx_t   in_rd_i;
  logic       in_ready_o;
  logic       res_v_o;
  word_t      res_data_o;
  reg_idx_t   res_rd_o;
  logic       res_illegal_o;

  integer     seed = 79;
  int         errors = 0;
  int         checks = 0;
  int         tick = 0;
  int         cycles = 0;
  int         issued = 0;
  logic       hold;
  logic       exp_ready;
  // non-CSR acceptance one and two cycles back
  logic       acc_op_1;
  logic       acc_op_2;
  logic [2:0] m_frm;
  fflags_t    m_fflags;

  word_t      exp_data_q [$];
  reg_idx_t   exp_rd_q [$];
  logic       exp_ill_q [$];
  int         exp_due_q [$];
  fflags_t    exp_flags_q [$];

  fp_op_e     op_table [7] = '{OP_FEQ, OP_FLT, OP_FLE, OP_FMIN, OP_FMAX, OP_CVT_W, OP_CVT_WU};
  logic [2:0] f3_table [6] = '{`FP_CSRRW_F3, `FP_CSRRS_F3, `FP_CSRRC_F3,
                               `FP_CSRRWI_F3, `FP_CSRRSI_F3, `FP_CSRRCI_F3};
  // dynamic rm weighted up so frm changes get exercised
  logic [2:0] rm_table [8] = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd4,
                               `FP_RM_DYN, `FP_RM_DYN, `FP_RM_DYN};

  fp_csr_top dut0 (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .in_v_i        (in_v_i),
    .in_op_i       (in_op_i),
    .in_funct3_i   (in_funct3_i),
    .in_rs1_i      (in_rs1_i),
    .in_csr_addr_i (in_csr_addr_i),
    .in_a_i        (in_a_i),
    .in_b_i        (in_b_i),
    .in_rd_i       (in_rd_i),
    .in_ready_o    (in_ready_o),
    .res_v_o       (res_v_o),
    .res_data_o    (res_data_o),
    .res_rd_o      (res_rd_o),
    .res_illegal_o (res_illegal_o)
  );

  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= timeout_limit) begin
      $display("timeout: run did not complete within %0d cycles", timeout_limit);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic expect_equal(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  function automatic word_t pick_operand();
    logic [31:0] r;
    logic [22:0] m;
    logic [7:0]  e;
    int          sel;
    int          sh;
    word_t       res;
    r   = $random(seed);
    sel = $unsigned($random(seed)) % 8;
    case (sel)
      0: res = {r[31], 8'hff, 1'b1, r[21:0]};
      1: res = {r[31], 8'hff, 1'b0, r[21:1], 1'b1};
      2: res = {r[31], 8'hff, 23'd0};
      3: res = {r[31], 31'd0};
      4, 5: begin
        // quarter steps from 1 up to 2^23, so ties show up often
        e  = 8'(127 + $unsigned($random(seed)) % 24);
        sh = 150 - int'(e);
        m  = r[22:0];
        if (sh >= 2) begin
          m = m & ~((23'd1 << (sh - 2)) - 23'd1);
        end
        res = {r[31], e, m};
      end
      6: res = {r[31], 8'(150 + $unsigned($random(seed)) % 16), r[22:0]};
      default: res = {r[31], 8'($unsigned($random(seed)) % 127), r[22:0]};
    endcase
    return res;
  endfunction

  // keys are monotonic in value with -0 below +0
  function automatic word_t cmp_reference(input fp_op_e op, input word_t a, input word_t b,
                                          output logic nv);
    logic  a_nan, b_nan, a_snan, b_snan, eq, lt;
    word_t ka, kb, res;
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 23'd0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 23'd0);
    a_snan = a_nan && !a[22];
    b_snan = b_nan && !b[22];
    ka     = a[31] ? ~a : {1'b1, a[30:0]};
    kb     = b[31] ? ~b : {1'b1, b[30:0]};
    eq     = !a_nan && !b_nan && ((a == b) || ((a[30:0] == 31'd0) && (b[30:0] == 31'd0)));
    lt     = !a_nan && !b_nan && !eq && (ka < kb);
    res    = '0;
    nv     = 1'b0;
    case (op)
      OP_FEQ: begin
        res = {31'd0, eq};
        nv  = a_snan || b_snan;
      end
      OP_FLT: begin
        res = {31'd0, lt};
        nv  = a_nan || b_nan;
      end
      OP_FLE: begin
        res = {31'd0, lt || eq};
        nv  = a_nan || b_nan;
      end
      default: begin
        nv = a_snan || b_snan;
        if (a_nan && b_nan) begin
          res = 32'h7fc0_0000;
        end else if (a_nan) begin
          res = b;
        end else if (b_nan) begin
          res = a;
        end else if (op == OP_FMIN) begin
          res = (ka < kb) ? a : b;
        end else begin
          res = (ka > kb) ? a : b;
        end
      end
    endcase
    return res;
  endfunction

  // exact integer part and remainder, then round in 64-bit signed space
  function automatic word_t cvt_reference(input fp_op_e op, input logic [2:0] rm,
                                          input word_t a, output fflags_t flags);
    logic [7:0]      e;
    logic            nan, neg, up, inexact, in_range;
    longint unsigned sig, whole, rem, half;
    longint          val;
    int              sh;
    word_t           res;
    e     = a[30:23];
    nan   = (e == 8'hff) && (a[22:0] != 23'd0);
    neg   = a[31] && !nan;
    sig   = {40'd0, e != 8'd0, a[22:0]};
    whole = 0;
    rem   = 0;
    half  = 1;
    if (e >= 8'd150) begin
      if (e < 8'd159) begin
        whole = sig << (e - 8'd150);
      end
    end else begin
      sh = 150 - int'(e);
      if (sh > 40) begin
        rem  = sig;
        half = 64'd1 << 40;
      end else begin
        whole = sig >> sh;
        rem   = sig & ((64'd1 << sh) - 64'd1);
        half  = 64'd1 << (sh - 1);
      end
    end
    inexact = rem != 0;
    case (rm)
      3'd1:    up = 1'b0;
      3'd2:    up = a[31] && inexact;
      3'd3:    up = !a[31] && inexact;
      3'd4:    up = rem >= half;
      default: up = (rem > half) || ((rem == half) && whole[0]);
    endcase
    val = longint'(whole);
    if (up) begin
      val = val + 1;
    end
    if (a[31]) begin
      val = -val;
    end
    if (op == OP_CVT_W) begin
      in_range = !nan && (e < 8'd159) && (val >= -64'sd2147483648) && (val <= 64'sd2147483647);
    end else begin
      in_range = !nan && (e < 8'd159) && (val >= 0) && (val <= 64'sd4294967295);
    end
    if (in_range) begin
      res   = val[31:0];
      flags = {4'b0000, inexact};
    end else begin
      flags = 5'b10000;
      if (op == OP_CVT_W) begin
        res = neg ? 32'h8000_0000 : 32'h7fff_ffff;
      end else begin
        res = neg ? 32'h0000_0000 : 32'hffff_ffff;
      end
    end
    return res;
  endfunction

  task automatic drive_instr();
    logic [31:0] r;
    int          sel;
    int          idx;
    r             = $random(seed);
    in_v_i        = 1'b1;
    in_rd_i       = r[4:0];
    in_rs1_i      = r[9:5];
    in_a_i        = $random(seed);
    in_b_i        = $random(seed);
    in_csr_addr_i = `FP_CSR_FCSR_ADDR;
    in_funct3_i   = 3'd0;
    sel           = $unsigned($random(seed)) % 10;
    if (sel < 3) begin
      in_op_i     = OP_CSR;
      idx         = $unsigned($random(seed)) % 6;
      in_funct3_i = f3_table[idx];
      case ($unsigned($random(seed)) % 8)
        0, 1, 2: in_csr_addr_i = `FP_CSR_FFLAGS_ADDR;
        3, 4:    in_csr_addr_i = `FP_CSR_FRM_ADDR;
        5, 6:    in_csr_addr_i = `FP_CSR_FCSR_ADDR;
        default: in_csr_addr_i = {2'b11, r[19:10]};
      endcase
    end else begin
      in_op_i = op_table[sel - 3];
      in_a_i  = pick_operand();
      // equal or sign-flipped pairs catch the zero and equality cases
      in_b_i  = r[10] ? pick_operand() : (in_a_i ^ {r[11], 31'd0});
      if ((in_op_i == OP_CVT_W) || (in_op_i == OP_CVT_WU)) begin
        in_funct3_i = rm_table[r[14:12]];
      end
    end
  endtask

  task automatic model_accept();
    fcsr_t      old, operand, nw;
    logic       illegal;
    logic       nv;
    fflags_t    flags;
    word_t      res;
    logic [2:0] rm;
    illegal = 1'b0;
    flags   = '0;
    if (in_op_i == OP_CSR) begin
      operand = in_funct3_i[2] ? {3'b000, in_rs1_i} : in_a_i[7:0];
      case (in_csr_addr_i)
        `FP_CSR_FFLAGS_ADDR: old = {3'b000, m_fflags};
        `FP_CSR_FRM_ADDR:    old = {5'b00000, m_frm};
        `FP_CSR_FCSR_ADDR:   old = {m_frm, m_fflags};
        default: begin
          old     = '0;
          illegal = 1'b1;
        end
      endcase
      case (in_funct3_i)
        `FP_CSRRW_F3, `FP_CSRRWI_F3: nw = operand;
        `FP_CSRRS_F3, `FP_CSRRSI_F3: nw = old | operand;
        default:                     nw = old & ~operand;
      endcase
      if (in_csr_addr_i == `FP_CSR_FFLAGS_ADDR) begin
        m_fflags = nw[4:0];
      end else if (in_csr_addr_i == `FP_CSR_FRM_ADDR) begin
        m_frm = nw[2:0];
      end else if (in_csr_addr_i == `FP_CSR_FCSR_ADDR) begin
        m_frm    = nw[7:5];
        m_fflags = nw[4:0];
      end
      res = {24'd0, old};
    end else if ((in_op_i == OP_CVT_W) || (in_op_i == OP_CVT_WU)) begin
      rm  = (in_funct3_i == `FP_RM_DYN) ? m_frm : in_funct3_i;
      res = cvt_reference(in_op_i, rm, in_a_i, flags);
    end else begin
      res   = cmp_reference(in_op_i, in_a_i, in_b_i, nv);
      flags = {nv, 4'b0000};
    end
    exp_data_q.push_back(res);
    exp_rd_q.push_back(in_rd_i);
    exp_ill_q.push_back(illegal);
    exp_flags_q.push_back(flags);
    exp_due_q.push_back(tick + `FP_PIPE_DEPTH);
  endtask

  // flags join the model's fflags as the result leaves
  task automatic collect_result();
    if (res_v_o) begin
      if (exp_due_q.size() == 0) begin
        errors++;
        $display("unexpected result at %0t with no instruction outstanding", $time);
      end else begin
        expect_equal("res_v_o cycle", 32'(exp_due_q.pop_front()), 32'(tick));
        expect_equal("res_data_o", exp_data_q.pop_front(), res_data_o);
        expect_equal("res_rd_o", 32'(exp_rd_q.pop_front()), 32'(res_rd_o));
        expect_equal("res_illegal_o", 32'(exp_ill_q.pop_front()), 32'(res_illegal_o));
        m_fflags = m_fflags | exp_flags_q.pop_front();
      end
    end else if ((exp_due_q.size() != 0) && (exp_due_q[0] <= tick)) begin
      errors++;
      $display("missing result at %0t, one was due in cycle %0d", $time, exp_due_q[0]);
      void'(exp_due_q.pop_front());
      void'(exp_data_q.pop_front());
      void'(exp_rd_q.pop_front());
      void'(exp_ill_q.pop_front());
      m_fflags = m_fflags | exp_flags_q.pop_front();
    end
  endtask

  initial begin
    reset_i       = 1'b1;
    in_v_i        = 1'b0;
    in_op_i       = OP_CSR;
    in_funct3_i   = 3'd0;
    in_rs1_i      = '0;
    in_csr_addr_i = '0;
    in_a_i        = '0;
    in_b_i        = '0;
    in_rd_i       = '0;
    m_frm         = 3'd0;
    m_fflags      = '0;
    acc_op_1      = 1'b0;
    acc_op_2      = 1'b0;
    hold          = 1'b0;
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    expect_equal("res_v_o", 32'd0, 32'(res_v_o));
    expect_equal("in_ready_o", 32'd1, 32'(in_ready_o));

    while ((issued < num_instr) || (exp_due_q.size() != 0)) begin
      @(negedge clk_i);
      tick++;
      collect_result();
      // a stalled instruction keeps its fields
      if (!hold) begin
        if ((issued < num_instr) && (($unsigned($random(seed)) % 8) != 0)) begin
          drive_instr();
        end else begin
          in_v_i = 1'b0;
        end
      end
      #1;
      exp_ready = !(in_v_i && (in_op_i == OP_CSR) && (acc_op_1 || acc_op_2));
      expect_equal("in_ready_o", 32'(exp_ready), 32'(in_ready_o));
      acc_op_2 = acc_op_1;
      acc_op_1 = 1'b0;
      hold     = in_v_i && !in_ready_o;
      if (in_v_i && in_ready_o) begin
        model_accept();
        issued++;
        acc_op_1 = in_op_i != OP_CSR;
      end
    end

    // nothing may arrive once the stream has drained
    repeat (4) begin
      @(negedge clk_i);
      tick++;
      collect_result();
    end

    $display("instructions: %0d checks: %0d errors: %0d", issued, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+design
design/fp_csr_pkg.sv
design/fp_op_pkg.sv
design/fcsr_unit.sv
design/fp_compare.sv
design/fp_cvt_int.sv
design/fp_issue_ctrl.sv
design/fp_csr_top.sv
verification/fp_csr_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fp_csr_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Verification passed$$" $(LOG) || { echo "test FAILED"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
